//--- Makefile
# verilator lint and simulation of mecobo_core
TOP   = mecobo_core_tb
FLIST = mecobo_core.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f $(FLIST)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/mecobo_core_sva.sv
//////////////////////////////
// assertions on the write strobe and the dac frame lines
//////////////////////////////
`timescale 1ns/1ps

module mecobo_core_sva (
  input logic                   sys_clk,
  input logic                   reset,
  input logic                   wr_strobe,
  input mecobo_pkg::dac_state_t state,
  input logic                   dac_sclk,
  input logic                   dac_din,
  input logic                   dac_nsync,
  input logic                   dac_nldac
);

  // one pulse per host write
  a_strobe_single: assert property (
    @(posedge sys_clk) disable iff (reset) wr_strobe |=> !wr_strobe
  ) else $error("wr_strobe high on two cycles in a row");

  // shift and load never overlap and load starts as nsync rises
  a_sync_load: assert property (
    @(posedge sys_clk) disable iff (reset)
      (dac_nsync || dac_nldac) && (!$rose(dac_nsync) || !dac_nldac)
  ) else $error("dac_nsync and dac_nldac out of order");

  // din only moves when sclk rises
  a_din_stable: assert property (
    @(posedge sys_clk) disable iff (reset)
      (!dac_nsync && !dac_sclk) |=> (dac_sclk || $stable(dac_din))
  ) else $error("dac_din changed while dac_sclk low");

  a_reset_idle: assert property (
    @(posedge sys_clk) reset |=> state == mecobo_pkg::dac_idle
  ) else $error("dac state not idle after reset");

endmodule

// wr_strobe at the dac input is the bus port output
bind dac_serial_ctrl mecobo_core_sva u_sva (
  .sys_clk   (sys_clk),
  .reset     (reset),
  .wr_strobe (wr_strobe),
  .state     (state),
  .dac_sclk  (dac_sclk),
  .dac_din   (dac_din),
  .dac_nsync (dac_nsync),
  .dac_nldac (dac_nldac)
);

//--- bench/mecobo_core_tb.sv
//////////////////////////////
// table-driven bus steps with pin and dac checks on mecobo_core
//////////////////////////////
`timescale 1ns/1ps
`include "mecobo_params.svh"

module mecobo_core_tb;

  typedef enum logic [2:0] {op_write, op_read, op_measure, op_dac, op_dac_busy} op_t;

  // measure steps carry the pin in addr and the window length in data
  // a zero window times one toggle interval instead
  typedef struct packed {
    op_t                   op;
    mecobo_pkg::bus_addr_t addr;
    mecobo_pkg::bus_word_t data;
    mecobo_pkg::bus_word_t expected;
  } step_t;

  localparam int PIN_TIMEOUT = 200;
  localparam int BUSY_POLLS = 40;
  localparam mecobo_pkg::bus_addr_t DAC_DATA = mecobo_pkg::bus_addr_t'(`DAC_BASE);
  localparam mecobo_pkg::bus_addr_t DAC_STATUS = mecobo_pkg::bus_addr_t'(`DAC_BASE + 1);

  logic                  sys_clk;
  logic                  reset;
  mecobo_pkg::bus_addr_t ebi_addr;
  mecobo_pkg::bus_word_t ebi_data_in;
  logic                  ebi_cs_n;
  logic                  ebi_wr_n;
  logic                  ebi_rd_n;
  mecobo_pkg::bus_word_t ebi_data_out;
  logic [`NUM_PINS-1:0]  pins;
  logic                  dac_sclk;
  logic                  dac_din;
  logic                  dac_nsync;
  logic                  dac_nldac;

  step_t steps [$];
  int    seed = 32'hc209;
  int    checks = 0;
  int    errors = 0;
  int    timeouts = 0;

  // square on pins 0 and 1 and pwm on pins 2 and 3
  mecobo_pkg::bus_word_t cfg_mode [`NUM_PINS] = '{16'd1, 16'd1, 16'd2, 16'd2};
  mecobo_pkg::bus_word_t cfg_period [`NUM_PINS] = '{16'd5, 16'd12, 16'd10, 16'd16};
  mecobo_pkg::bus_word_t cfg_duty [`NUM_PINS] = '{16'd2, 16'd7, 16'd3, 16'd11};

  // serial line monitor state
  logic                  sclk_seen = 1'b1;
  logic                  nldac_seen = 1'b1;
  mecobo_pkg::bus_word_t cap_word = '0;
  int                    cap_bits = 0;
  int                    nldac_pulses = 0;

  mecobo_core UUT (.*);

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = !sys_clk;
  end

  // din as the converter takes it on falling sclk inside the frame
  always @(negedge sys_clk) begin
    sclk_seen  <= dac_sclk;
    nldac_seen <= dac_nldac;
    if (sclk_seen && !dac_sclk && !dac_nsync) begin
      cap_word <= {cap_word[14:0], dac_din};
      cap_bits <= cap_bits + 1;
    end
    if (nldac_seen && !dac_nldac) begin
      nldac_pulses <= nldac_pulses + 1;
    end
  end

  task automatic check_word(input string what, input mecobo_pkg::bus_word_t got,
                            input mecobo_pkg::bus_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic check_tick(input string what, input mecobo_pkg::tick_t got,
                            input mecobo_pkg::tick_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  function automatic mecobo_pkg::bus_addr_t pin_addr(input int n, input int off);
    return mecobo_pkg::bus_addr_t'(`PIN_BASE + n * `PIN_STRIDE + off);
  endfunction

  // select then hold wr_n low long enough for the synchronizer
  task automatic bus_write(input mecobo_pkg::bus_addr_t addr, input mecobo_pkg::bus_word_t data);
    @(posedge sys_clk);
    ebi_addr    <= addr;
    ebi_data_in <= data;
    ebi_cs_n    <= 1'b0;
    repeat (2) @(posedge sys_clk);
    ebi_wr_n <= 1'b0;
    repeat (4) @(posedge sys_clk);
    ebi_wr_n <= 1'b1;
    @(posedge sys_clk);
    ebi_cs_n <= 1'b1;
    repeat (2) @(posedge sys_clk);
  endtask

  // data_out is valid two cycles after the registered strobes
  task automatic bus_read(input mecobo_pkg::bus_addr_t addr, output mecobo_pkg::bus_word_t data);
    @(posedge sys_clk);
    ebi_addr <= addr;
    ebi_cs_n <= 1'b0;
    ebi_rd_n <= 1'b0;
    repeat (4) @(posedge sys_clk);
    @(negedge sys_clk);
    data = ebi_data_out;
    @(posedge sys_clk);
    ebi_cs_n <= 1'b1;
    ebi_rd_n <= 1'b1;
    repeat (2) @(posedge sys_clk);
  endtask

  // counts negedges until the pin changes level
  task automatic wait_toggle(input int idx, output int cycles);
    logic lvl;
    lvl = pins[idx];
    cycles = 0;
    do begin
      @(negedge sys_clk);
      cycles++;
    end while (pins[idx] === lvl && cycles < PIN_TIMEOUT);
    if (pins[idx] === lvl) begin
      timeouts++;
      $display("pin %0d did not toggle within %0d cycles", idx, PIN_TIMEOUT);
    end
  endtask

  task automatic dac_frame(input mecobo_pkg::bus_word_t word,
                           input mecobo_pkg::bus_word_t expected, input logic overlap);
    mecobo_pkg::bus_word_t status;
    int bits0;
    int pulses0;
    int polls;
    bits0 = cap_bits;
    pulses0 = nldac_pulses;
    bus_write(DAC_DATA, word);
    // second word lands mid frame
    if (overlap) begin
      bus_write(DAC_DATA, ~word);
    end
    bus_read(DAC_STATUS, status);
    check_word("dac busy during frame", status, 16'h1);
    polls = 0;
    while (status[0] && polls < BUSY_POLLS) begin
      bus_read(DAC_STATUS, status);
      polls++;
    end
    if (status[0]) begin
      timeouts++;
      $display("dac still busy after %0d status polls", polls);
    end
    check_word("dac busy after frame", status, 16'h0);
    check_tick("dac bits per frame", mecobo_pkg::tick_t'(cap_bits - bits0), 16'd16);
    check_word("dac serial word", cap_word, expected);
    check_tick("dac nldac pulses", mecobo_pkg::tick_t'(nldac_pulses - pulses0), 16'd1);
  endtask

  task automatic run_step(input step_t s);
    mecobo_pkg::bus_word_t got;
    int cycles;
    int idx;
    idx = int'(s.addr);
    case (s.op)
      op_write: bus_write(s.addr, s.data);
      op_read: begin
        bus_read(s.addr, got);
        check_word($sformatf("read at 0x%0h", s.addr), got, s.expected);
      end
      op_measure: begin
        cycles = 0;
        if (s.data == '0) begin
          // align on one toggle and time the next
          @(negedge sys_clk);
          wait_toggle(idx, cycles);
          wait_toggle(idx, cycles);
        end else begin
          repeat (2) @(negedge sys_clk);
          repeat (s.data) begin
            @(negedge sys_clk);
            if (pins[idx]) cycles++;
          end
        end
        check_tick($sformatf("pin %0d measure", idx), mecobo_pkg::tick_t'(cycles), s.expected);
      end
      default: dac_frame(s.data, s.expected, s.op == op_dac_busy);
    endcase
  endtask

  function automatic void add_step(input op_t op, input mecobo_pkg::bus_addr_t addr,
                                   input mecobo_pkg::bus_word_t data,
                                   input mecobo_pkg::bus_word_t expected);
    steps.push_back(step_t'{op, addr, data, expected});
  endfunction

  function automatic void build_steps();
    mecobo_pkg::tick_t period;
    mecobo_pkg::tick_t duty;
    int rnd;
    // reset state first then program and read back each window
    for (int n = 0; n < `NUM_PINS; n++) begin
      add_step(op_read, pin_addr(n, `REG_MODE), '0, '0);
      add_step(op_measure, mecobo_pkg::bus_addr_t'(n), 16'd16, '0);
    end
    add_step(op_read, DAC_STATUS, '0, '0);
    for (int n = 0; n < `NUM_PINS; n++) begin
      add_step(op_write, pin_addr(n, `REG_MODE), cfg_mode[n], '0);
      add_step(op_write, pin_addr(n, `REG_PERIOD), cfg_period[n], '0);
      add_step(op_write, pin_addr(n, `REG_DUTY), cfg_duty[n], '0);
      add_step(op_read, pin_addr(n, `REG_MODE), '0, cfg_mode[n]);
      add_step(op_read, pin_addr(n, `REG_PERIOD), '0, cfg_period[n]);
      add_step(op_read, pin_addr(n, `REG_DUTY), '0, cfg_duty[n]);
    end
    // unmapped words and a spare slot
    add_step(op_read, mecobo_pkg::bus_addr_t'('h10), '0, '0);
    add_step(op_read, mecobo_pkg::bus_addr_t'('h2ff), '0, '0);
    add_step(op_read, pin_addr(0, 5), '0, '0);
    // square gives a toggle interval and pwm a high count per period
    for (int n = 0; n < `NUM_PINS; n++) begin
      if (cfg_mode[n] == 16'd1) begin
        add_step(op_measure, mecobo_pkg::bus_addr_t'(n), '0, cfg_period[n]);
      end else begin
        add_step(op_measure, mecobo_pkg::bus_addr_t'(n), cfg_period[n], cfg_duty[n]);
      end
    end
    // random pwm on pins 2 and 3 with duty kept below period
    for (int k = 0; k < 4; k++) begin
      rnd = $random(seed);
      period = mecobo_pkg::tick_t'(6 + (rnd & 31));
      duty = rnd[23:8] % period;
      add_step(op_write, pin_addr(2 + k % 2, `REG_MODE), 16'd2, '0);
      add_step(op_write, pin_addr(2 + k % 2, `REG_PERIOD), period, '0);
      add_step(op_write, pin_addr(2 + k % 2, `REG_DUTY), duty, '0);
      add_step(op_measure, mecobo_pkg::bus_addr_t'(2 + k % 2), period, duty);
    end
    // off mode and zero period both hold the pin low
    add_step(op_write, pin_addr(1, `REG_MODE), 16'd0, '0);
    add_step(op_measure, mecobo_pkg::bus_addr_t'(1), 16'd40, '0);
    add_step(op_read, pin_addr(1, `REG_LAST), '0, '0);
    add_step(op_write, pin_addr(0, `REG_PERIOD), 16'd0, '0);
    add_step(op_measure, mecobo_pkg::bus_addr_t'(0), 16'd40, '0);
    add_step(op_dac, DAC_DATA, 16'ha5c3, 16'ha5c3);
    add_step(op_dac, DAC_DATA, 16'h8001, 16'h8001);
    add_step(op_dac_busy, DAC_DATA, 16'h3c5a, 16'h3c5a);
    // dropped word never reaches the data register
    add_step(op_read, DAC_DATA, '0, 16'h3c5a);
  endfunction

  initial begin
    reset = 1'b1;
    ebi_addr = '0;
    ebi_data_in = '0;
    ebi_cs_n = 1'b1;
    ebi_wr_n = 1'b1;
    ebi_rd_n = 1'b1;
    build_steps();
    repeat (2) @(posedge sys_clk);
    reset <= 1'b0;
    @(negedge sys_clk);
    for (int n = 0; n < `NUM_PINS; n++) begin
      check_level($sformatf("pin %0d after reset", n), pins[n], 1'b0);
    end
    check_level("dac_sclk after reset", dac_sclk, 1'b1);
    check_level("dac_nsync after reset", dac_nsync, 1'b1);
    check_level("dac_nldac after reset", dac_nldac, 1'b1);
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- mecobo_core.f
+incdir+src
src/mecobo_pkg.sv
src/host_bus_port.sv
src/pin_waveform_gen.sv
src/dac_serial_ctrl.sv
src/mecobo_core.sv
bench/mecobo_core_sva.sv
bench/mecobo_core_tb.sv

//--- src/dac_serial_ctrl.sv
//////////////////////////////
// serial dac: one 16-bit frame per data write, busy in status
//////////////////////////////
`timescale 1ns/1ps
`include "mecobo_params.svh"

module dac_serial_ctrl (
  input  logic                  sys_clk,
  input  logic                  reset,
  input  mecobo_pkg::bus_addr_t bus_addr,
  input  mecobo_pkg::bus_word_t wr_data,
  input  logic                  wr_strobe,
  output mecobo_pkg::bus_word_t rd_data,
  output logic                  dac_sclk,
  output logic                  dac_din,
  output logic                  dac_nsync,
  output logic                  dac_nldac
);

  // divider and bit counter widths
  localparam int DIV_W = $clog2(`DAC_CLK_DIV + 1);
  localparam int CNT_W = $clog2(`DAC_BITS);

  mecobo_pkg::dac_state_t state;
  logic [DIV_W-1:0]       div_cnt;
  logic                   half_tick;
  logic [CNT_W-1:0]       bit_cnt;
  logic [`DAC_BITS-1:0]   shift_reg;
  mecobo_pkg::bus_word_t  last_word;

  // decode and control
  logic data_hit;
  logic status_hit;
  logic busy;
  logic start;

  assign data_hit   = bus_addr == mecobo_pkg::bus_addr_t'(`DAC_BASE);
  assign status_hit = bus_addr == mecobo_pkg::bus_addr_t'(`DAC_BASE + 1);
  assign busy       = state != mecobo_pkg::dac_idle;
  // writes during a frame are dropped
  assign start      = wr_strobe && data_hit && !busy;
  assign half_tick  = div_cnt == DIV_W'(`DAC_CLK_DIV - 1);

  // frame strobes follow the state directly
  assign dac_nsync  = state != mecobo_pkg::dac_shift;
  assign dac_nldac  = state != mecobo_pkg::dac_load;
  // msb first
  assign dac_din    = shift_reg[`DAC_BITS-1];

  // half period divider, held at zero when idle
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      div_cnt <= '0;
    end else if (!busy || half_tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // frame fsm
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      state     <= mecobo_pkg::dac_idle;
      dac_sclk  <= 1'b1;
      bit_cnt   <= '0;
      shift_reg <= '0;
    end else begin
      case (state)
        mecobo_pkg::dac_idle: begin
          if (start) begin
            shift_reg <= wr_data[`DAC_BITS-1:0];
            bit_cnt   <= '0;
            state     <= mecobo_pkg::dac_shift;
          end
        end
        mecobo_pkg::dac_shift: begin
          if (half_tick) begin
            if (dac_sclk) begin
              // falling edge, converter samples din here
              dac_sclk <= 1'b0;
            end else begin
              dac_sclk <= 1'b1;
              if (bit_cnt == CNT_W'(`DAC_BITS - 1)) begin
                state <= mecobo_pkg::dac_load;
              end else begin
                // next bit goes out while sclk is high
                bit_cnt   <= bit_cnt + 1'b1;
                shift_reg <= {shift_reg[`DAC_BITS-2:0], 1'b0};
              end
            end
          end
        end
        mecobo_pkg::dac_load: begin
          // nldac pulse is one half period
          if (half_tick) begin
            state <= mecobo_pkg::dac_idle;
          end
        end
        default: state <= mecobo_pkg::dac_idle;
      endcase
    end
  end

  // copy of the word in flight, for read back
  always_ff @(posedge sys_clk) begin
    if (start) begin
      last_word <= wr_data;
    end
  end

  // data at +0, busy at +1
  always_comb begin
    rd_data = '0;
    if (data_hit) begin
      rd_data = last_word;
    end else if (status_hit) begin
      rd_data = mecobo_pkg::bus_word_t'(busy);
    end
  end

endmodule

//--- src/host_bus_port.sv
//////////////////////////////
// host side of the external bus: strobe sync, write pulse, read mux
//////////////////////////////
`timescale 1ns/1ps
`include "mecobo_params.svh"

module host_bus_port (
  input  logic                  sys_clk,
  input  logic                  reset,
  input  mecobo_pkg::bus_addr_t ebi_addr,
  input  mecobo_pkg::bus_word_t ebi_data_in,
  input  logic                  ebi_cs_n,
  input  logic                  ebi_wr_n,
  input  logic                  ebi_rd_n,
  input  mecobo_pkg::bus_word_t pin_rd_data [`NUM_PINS],
  input  mecobo_pkg::bus_word_t dac_rd_data,
  output mecobo_pkg::bus_addr_t bus_addr,
  output mecobo_pkg::bus_word_t wr_data,
  output logic                  wr_strobe,
  output mecobo_pkg::bus_word_t ebi_data_out
);

  // first stage, strobes inverted to active high
  logic cs_q;
  logic wr_q;
  logic rd_q;
  mecobo_pkg::bus_addr_t addr_q;
  mecobo_pkg::bus_word_t data_q;

  // second stage
  logic wr_prev;
  logic write_edge;
  logic rd_en;

  // or of every peripheral read word
  mecobo_pkg::bus_word_t rd_any;

  // control path
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      cs_q         <= 1'b0;
      wr_q         <= 1'b0;
      rd_q         <= 1'b0;
      wr_prev      <= 1'b0;
      write_edge   <= 1'b0;
      wr_strobe    <= 1'b0;
      rd_en        <= 1'b0;
      ebi_data_out <= '0;
    end else begin
      cs_q       <= !ebi_cs_n;
      wr_q       <= !ebi_wr_n;
      rd_q       <= !ebi_rd_n;
      wr_prev    <= wr_q;
      // falling wr_n seen while selected
      write_edge <= cs_q && wr_q && !wr_prev;
      // one more stage lines the pulse up with bus_addr
      wr_strobe  <= write_edge;
      rd_en      <= cs_q && rd_q;
      // bus reads zero when nobody is reading
      ebi_data_out <= rd_en ? rd_any : '0;
    end
  end

  // address and write data, two stages like the strobe
  always_ff @(posedge sys_clk) begin
    addr_q   <= ebi_addr;
    data_q   <= ebi_data_in;
    bus_addr <= addr_q;
    wr_data  <= data_q;
  end

  // peripherals return zero outside their window, so a plain or works
  always_comb begin
    rd_any = dac_rd_data;
    for (int n = 0; n < `NUM_PINS; n++) begin
      rd_any = rd_any | pin_rd_data[n];
    end
  end

endmodule

//--- src/mecobo_core.sv
//////////////////////////////
// top level: host port, pin generators and dac on one bus
//////////////////////////////
`timescale 1ns/1ps
`include "mecobo_params.svh"

module mecobo_core (
  input  logic                  sys_clk,
  input  logic                  reset,
  input  mecobo_pkg::bus_addr_t ebi_addr,
  input  mecobo_pkg::bus_word_t ebi_data_in,
  input  logic                  ebi_cs_n,
  input  logic                  ebi_wr_n,
  input  logic                  ebi_rd_n,
  output mecobo_pkg::bus_word_t ebi_data_out,
  output logic [`NUM_PINS-1:0]  pins,
  output logic                  dac_sclk,
  output logic                  dac_din,
  output logic                  dac_nsync,
  output logic                  dac_nldac
);

  // shared write side
  mecobo_pkg::bus_addr_t bus_addr;
  mecobo_pkg::bus_word_t wr_data;
  logic                  wr_strobe;

  // per peripheral read words
  mecobo_pkg::bus_word_t pin_rd_data [`NUM_PINS];
  mecobo_pkg::bus_word_t dac_rd_data;

  host_bus_port u_bus (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .ebi_addr     (ebi_addr),
    .ebi_data_in  (ebi_data_in),
    .ebi_cs_n     (ebi_cs_n),
    .ebi_wr_n     (ebi_wr_n),
    .ebi_rd_n     (ebi_rd_n),
    .pin_rd_data  (pin_rd_data),
    .dac_rd_data  (dac_rd_data),
    .bus_addr     (bus_addr),
    .wr_data      (wr_data),
    .wr_strobe    (wr_strobe),
    .ebi_data_out (ebi_data_out)
  );

  // each generator decodes its own window
  for (genvar i = 0; i < `NUM_PINS; i++) begin : g_pin
    pin_waveform_gen #(.pin_index(i)) u_pin (
      .sys_clk   (sys_clk),
      .reset     (reset),
      .bus_addr  (bus_addr),
      .wr_data   (wr_data),
      .wr_strobe (wr_strobe),
      .rd_data   (pin_rd_data[i]),
      .pin       (pins[i])
    );
  end

  dac_serial_ctrl u_dac (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .bus_addr  (bus_addr),
    .wr_data   (wr_data),
    .wr_strobe (wr_strobe),
    .rd_data   (dac_rd_data),
    .dac_sclk  (dac_sclk),
    .dac_din   (dac_din),
    .dac_nsync (dac_nsync),
    .dac_nldac (dac_nldac)
  );

endmodule

//--- src/mecobo_params.svh
//////////////////////////////
// pin count, address map, register offsets and dac timing
// include wherever the map or the mode codes are needed
//////////////////////////////
`ifndef MECOBO_PARAMS_SVH
`define MECOBO_PARAMS_SVH

// number of pin generators
`define NUM_PINS 4

// pin n lives at PIN_BASE + n * PIN_STRIDE
`define PIN_BASE 'h32
`define PIN_STRIDE 8

// pin register offsets
`define REG_MODE 0
`define REG_PERIOD 1
`define REG_DUTY 2
// read only
`define REG_TICK 3
// read only, level in bit 0
`define REG_LAST 4

// waveform selector codes
`define MODE_OFF 0
`define MODE_SQUARE 1
`define MODE_PWM 2

// dac data at +0, status (busy in bit 0) at +1
`define DAC_BASE 'h100
// sys_clk cycles per half serial clock
`define DAC_CLK_DIV 2
`define DAC_BITS 16

`endif

//--- src/mecobo_pkg.sv
//////////////////////////////
// shared types for the host bus, the pins and the dac
//////////////////////////////
package mecobo_pkg;

  // host word address
  typedef logic [20:0] bus_addr_t;

  // host data word, one register per address
  typedef logic [15:0] bus_word_t;

  // pin tick counter, period and duty
  typedef logic [15:0] tick_t;

  // waveform selector, codes in the params header
  typedef logic [1:0] pin_mode_t;

  // dac frame states
  typedef enum logic [1:0] {
    // lines parked high
    dac_idle,
    // nsync low, bits going out
    dac_shift,
    // nldac low for half a serial period
    dac_load
  } dac_state_t;

endpackage

//--- src/pin_waveform_gen.sv
//////////////////////////////
// one pin: off, square or pwm level on its output
// registers at PIN_BASE + pin_index * PIN_STRIDE
//////////////////////////////
`timescale 1ns/1ps
`include "mecobo_params.svh"

module pin_waveform_gen #(
  parameter int pin_index = 0
) (
  input  logic                  sys_clk,
  input  logic                  reset,
  input  mecobo_pkg::bus_addr_t bus_addr,
  input  mecobo_pkg::bus_word_t wr_data,
  input  logic                  wr_strobe,
  output mecobo_pkg::bus_word_t rd_data,
  output logic                  pin
);

  // window start for this pin
  localparam int WIN_BASE = `PIN_BASE + pin_index * `PIN_STRIDE;
  // offset bits inside the window
  localparam int SEL_W = $clog2(`PIN_STRIDE);

  // decode
  mecobo_pkg::bus_addr_t win_offset;
  logic [SEL_W-1:0]      reg_sel;
  logic                  win_hit;
  logic                  win_write;

  // config registers
  mecobo_pkg::pin_mode_t mode;
  mecobo_pkg::tick_t     period;
  mecobo_pkg::tick_t     duty;

  // waveform state
  mecobo_pkg::tick_t     tick;
  logic                  run;
  logic                  period_end;
  logic                  is_square;
  logic                  is_pwm;

  // below the base wraps high, so one compare covers both ends
  assign win_offset = bus_addr - mecobo_pkg::bus_addr_t'(WIN_BASE);
  assign win_hit    = win_offset < mecobo_pkg::bus_addr_t'(`PIN_STRIDE);
  assign reg_sel    = win_offset[SEL_W-1:0];
  assign win_write  = wr_strobe && win_hit;

  assign is_square  = mode == mecobo_pkg::pin_mode_t'(`MODE_SQUARE);
  assign is_pwm     = mode == mecobo_pkg::pin_mode_t'(`MODE_PWM);
  // zero period behaves as off, and so does the spare code 3
  assign run        = (period != '0) && (is_square || is_pwm);
  // last count of a period
  assign period_end = tick == period - 1'b1;

  // register writes
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      mode   <= mecobo_pkg::pin_mode_t'(`MODE_OFF);
      period <= '0;
      duty   <= '0;
    end else if (win_write) begin
      case (reg_sel)
        SEL_W'(`REG_MODE):   mode   <= wr_data[1:0];
        SEL_W'(`REG_PERIOD): period <= wr_data;
        SEL_W'(`REG_DUTY):   duty   <= wr_data;
        // tick and last are read only
        default: ;
      endcase
    end
  end

  // tick counter and pin level
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      tick <= '0;
      pin  <= 1'b0;
    end else if (win_write || !run) begin
      // any write restarts the waveform from low
      tick <= '0;
      pin  <= 1'b0;
    end else if (is_square) begin
      // toggle once per period
      if (period_end) begin
        tick <= '0;
        pin  <= !pin;
      end else begin
        tick <= tick + 1'b1;
      end
    end else begin
      // pwm: high for the first duty counts of each period
      tick <= period_end ? '0 : tick + 1'b1;
      pin  <= tick < duty;
    end
  end

  // read back, zero outside the window
  always_comb begin
    rd_data = '0;
    if (win_hit) begin
      case (reg_sel)
        SEL_W'(`REG_MODE):   rd_data = mecobo_pkg::bus_word_t'(mode);
        SEL_W'(`REG_PERIOD): rd_data = period;
        SEL_W'(`REG_DUTY):   rd_data = duty;
        SEL_W'(`REG_TICK):   rd_data = tick;
        SEL_W'(`REG_LAST):   rd_data = mecobo_pkg::bus_word_t'(pin);
        default:             rd_data = '0;
      endcase
    end
  end

endmodule
